// File: src.f
rtl/alu_rs_pkg.sv
rtl/rs_entry_if.sv
rtl/exec_req_if.sv
rtl/dispatch_decode.sv
rtl/rs_station.sv
rtl/exec_unit.sv
rtl/alu_rs_top.sv
testbench/alu_rs_assertions.sv
testbench/tb_alu_rs.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_alu_rs
FILELIST  ?= src.f
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: testbench/tb_alu_rs.sv
`timescale 1ns/10ps

module tb_alu_rs
  import alu_rs_pkg::*;
();

  localparam int NUM_ENTRIES = 8;
  localparam int ROB_TAG_W   = 3;
  localparam int CDB_PORTS   = 3;

  typedef logic [ROB_TAG_W-1:0] tag_t;

  logic    clk;
  logic    rst;
  logic    flush;
  logic    issue;
  opcode_t issue_opcode;
  logic [2:0] issue_funct3;
  logic [6:0] issue_funct7;
  word_t   issue_imm;
  word_t   issue_pc;
  tag_t    issue_rob;
  logic    rs1_ready;
  logic    rs2_ready;
  word_t   rs1_value;
  word_t   rs2_value;
  tag_t    rs1_rob;
  tag_t    rs2_rob;
  logic    cdb_valid [CDB_PORTS];
  tag_t    cdb_rob   [CDB_PORTS];
  word_t   cdb_value [CDB_PORTS];
  logic    full;
  logic    result_valid;
  word_t   result_value;
  tag_t    result_rob;

  // scoreboard state, one slot per rob tag
  logic  pending  [1 << ROB_TAG_W];
  word_t expected [1 << ROB_TAG_W];
  int    pending_n;
  int    results_seen;
  int    errors;
  int    checks;
  string test_name;

  alu_rs_top i_dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // reference result from opcode, funct3 and the alternate bit
  function automatic word_t model(opcode_t opc, logic [2:0] f3, logic alt, word_t a, word_t b);
    if (opc == opc_lui) return b;
    if (opc == opc_auipc) return a + b;
    case (f3)
      FUNCT3_ADD_SUB: return (alt && opc == opc_op) ? a - b : a + b;
      FUNCT3_SLL:     return a << b[4:0];
      FUNCT3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      FUNCT3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      FUNCT3_XOR:     return a ^ b;
      FUNCT3_SR:      return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      FUNCT3_OR:      return a | b;
      default:        return a & b;
    endcase
  endfunction

  task automatic check_value(string name, word_t exp, word_t act);
    checks++;
    assert (exp == act) else begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(logic cond, string what);
    checks++;
    assert (cond) else begin
      $display("%s: %s", test_name, what);
      errors++;
    end
  endtask

  // compare each returned result at the falling edge
  always @(negedge clk) begin
    if (!rst && result_valid) begin
      results_seen++;
      checks++;
      assert (pending[result_rob]) else begin
        $display("%s: result for rob tag %0d with nothing outstanding", test_name, result_rob);
        errors++;
      end
      if (pending[result_rob]) begin
        check_value(test_name, expected[result_rob], result_value);
        pending[result_rob] = 1'b0;
        pending_n--;
      end
    end
  end

  task automatic expect_tag(tag_t tag, word_t value);
    pending[tag]  = 1'b1;
    expected[tag] = value;
    pending_n++;
  endtask

  task automatic issue_instr(opcode_t opc, logic [2:0] f3, logic [6:0] f7, word_t imm,
                             word_t pc, tag_t rob, logic r1_rdy, word_t r1_val,
                             tag_t r1_tag, logic r2_rdy, word_t r2_val, tag_t r2_tag);
    @(negedge clk);
    issue        = 1'b1;
    issue_opcode = opc;
    issue_funct3 = f3;
    issue_funct7 = f7;
    issue_imm    = imm;
    issue_pc     = pc;
    issue_rob    = rob;
    rs1_ready    = r1_rdy;
    rs1_value    = r1_val;
    rs1_rob      = r1_tag;
    rs2_ready    = r2_rdy;
    rs2_value    = r2_val;
    rs2_rob      = r2_tag;
    @(negedge clk);
    issue = 1'b0;
  endtask

  // one cdb port for a single cycle
  task automatic broadcast(int port, tag_t tag, word_t value);
    @(negedge clk);
    cdb_valid[port] = 1'b1;
    cdb_rob[port]   = tag;
    cdb_value[port] = value;
    @(negedge clk);
    cdb_valid[port] = 1'b0;
  endtask

  task automatic wait_idle();
    for (int i = 0; i < 64 && pending_n != 0; i++) begin
      @(negedge clk);
      #1;
    end
    if (pending_n != 0) begin
      $display("%s: timed out with %0d results still missing", test_name, pending_n);
      $display("** FAIL **");
      $finish;
    end
  endtask

  task automatic finish_test(int errors_before);
    $display("test %s finished with %0d errors", test_name, errors - errors_before);
  endtask

  initial begin
    int    e0;
    int    seen;
    tag_t  tag;
    word_t a;
    word_t b;
    word_t v;
    word_t ops [NUM_ENTRIES];
    void'($urandom(32'haf92e371));
    rst = 1'b1;
    flush = 1'b0;
    issue = 1'b0;
    issue_opcode = opc_op;
    issue_funct3 = '0;
    issue_funct7 = '0;
    issue_imm = '0;
    issue_pc = '0;
    issue_rob = '0;
    rs1_ready = 1'b0;
    rs2_ready = 1'b0;
    rs1_value = '0;
    rs2_value = '0;
    rs1_rob = '0;
    rs2_rob = '0;
    for (int p = 0; p < CDB_PORTS; p++) begin
      cdb_valid[p] = 1'b0;
      cdb_rob[p]   = '0;
      cdb_value[p] = '0;
    end
    for (int t = 0; t < (1 << ROB_TAG_W); t++) pending[t] = 1'b0;
    pending_n = 0;
    results_seen = 0;
    errors = 0;
    checks = 0;
    tag = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // every funct3 and alternate bit, register and immediate forms
    test_name = "alu_ops";
    e0 = errors;
    for (int k = 0; k < 2; k++) begin
      for (int f = 0; f < 8; f++) begin
        for (int alt = 0; alt < 2; alt++) begin
          a = $urandom;
          b = $urandom;
          v = $urandom;
          if (k == 0) begin
            expect_tag(tag, model(opc_op_imm, 3'(f), 1'(alt), a, b));
            issue_instr(opc_op_imm, 3'(f), 7'(alt << 5), b, '0, tag, 1'b1, a, '0,
                        1'b0, v, '0);
          end else begin
            expect_tag(tag, model(opc_op, 3'(f), 1'(alt), a, b));
            issue_instr(opc_op, 3'(f), 7'(alt << 5), v, '0, tag, 1'b1, a, '0,
                        1'b1, b, '0);
          end
          wait_idle();
          tag++;
        end
      end
    end
    finish_test(e0);

    test_name = "lui_auipc";
    e0 = errors;
    a = $urandom;
    b = $urandom;
    expect_tag(tag, b);
    issue_instr(opc_lui, '0, '0, b, a, tag, 1'b0, $urandom, '0, 1'b0, $urandom, '0);
    wait_idle();
    tag++;
    expect_tag(tag, a + b);
    issue_instr(opc_auipc, '0, '0, b, a, tag, 1'b0, $urandom, '0, 1'b0, $urandom, '0);
    wait_idle();
    finish_test(e0);

    // sub waits on rs1 tag 5
    test_name = "cdb_wakeup";
    e0 = errors;
    b = $urandom;
    seen = results_seen;
    issue_instr(opc_op, FUNCT3_ADD_SUB, 7'h20, '0, '0, 3'd2, 1'b0, '0, 3'd5, 1'b1, b, '0);
    repeat (5) @(negedge clk);
    #1;
    check_true(results_seen == seen, "result appeared before any broadcast");
    broadcast(0, 3'd6, $urandom);
    repeat (4) @(negedge clk);
    #1;
    check_true(results_seen == seen, "non-matching tag woke the entry");
    v = $urandom;
    expect_tag(3'd2, v - b);
    broadcast(2, 3'd5, v);
    wait_idle();
    // xor waits on both sources, woken in one cycle
    issue_instr(opc_op, FUNCT3_XOR, '0, '0, '0, 3'd3, 1'b0, '0, 3'd1, 1'b0, '0, 3'd4);
    a = $urandom;
    b = $urandom;
    expect_tag(3'd3, a ^ b);
    @(negedge clk);
    cdb_valid[0] = 1'b1;
    cdb_rob[0]   = 3'd1;
    cdb_value[0] = a;
    cdb_valid[1] = 1'b1;
    cdb_rob[1]   = 3'd4;
    cdb_value[1] = b;
    @(negedge clk);
    cdb_valid[0] = 1'b0;
    cdb_valid[1] = 1'b0;
    wait_idle();
    finish_test(e0);

    test_name = "fill_drain";
    e0 = errors;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      ops[i] = $urandom;
      issue_instr(opc_op, 3'(i), '0, '0, '0, tag_t'(i), 1'b0, '0, tag_t'(i),
                  1'b1, ops[i], '0);
    end
    #1;
    check_true(full == 1'b1, "full not set with every entry waiting");
    for (int k = 0; k < NUM_ENTRIES; k += CDB_PORTS) begin
      @(negedge clk);
      for (int p = 0; p < CDB_PORTS; p++) begin
        cdb_valid[p] = 1'b0;
        if (k + p < NUM_ENTRIES) begin
          a = $urandom;
          expect_tag(tag_t'(k + p), model(opc_op, 3'(k + p), 1'b0, a, ops[k + p]));
          cdb_valid[p] = 1'b1;
          cdb_rob[p]   = tag_t'(k + p);
          cdb_value[p] = a;
        end
      end
    end
    @(negedge clk);
    for (int p = 0; p < CDB_PORTS; p++) cdb_valid[p] = 1'b0;
    wait_idle();
    check_true(full == 1'b0, "full still set after drain");
    finish_test(e0);

    // three waiting entries, one request reaching execute
    test_name = "flush";
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      issue_instr(opc_op, FUNCT3_OR, '0, '0, '0, tag_t'(i), 1'b0, '0, tag_t'(4 + i),
                  1'b1, $urandom, '0);
    end
    a = $urandom;
    expect_tag(3'd3, a + 32'd1);
    issue_instr(opc_op_imm, FUNCT3_ADD_SUB, '0, 32'd1, '0, 3'd3, 1'b1, a, '0,
                1'b0, '0, '0);
    @(negedge clk);
    flush = 1'b1;
    for (int t = 0; t < (1 << ROB_TAG_W); t++) pending[t] = 1'b0;
    pending_n = 0;
    seen = results_seen;
    @(negedge clk);
    flush = 1'b0;
    broadcast(0, 3'd4, $urandom);
    repeat (6) @(negedge clk);
    #1;
    check_true(results_seen == seen, "flushed instruction returned a result");
    check_true(full == 1'b0, "full set after flush");
    a = $urandom;
    b = $urandom;
    expect_tag(3'd6, a & b);
    issue_instr(opc_op, FUNCT3_AND, '0, '0, '0, 3'd6, 1'b1, a, '0, 1'b1, b, '0);
    wait_idle();
    finish_test(e0);

    // failed bound properties count as errors too
    errors += i_dut.i_assertions.fail_count;
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: testbench/alu_rs_assertions.sv
`timescale 1ns/10ps

module alu_rs_assertions
  import alu_rs_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    flush,
  input logic    issue,
  input opcode_t issue_opcode,
  input logic    rs1_ready,
  input logic    rs2_ready,
  input logic    full,
  input logic    result_valid
);

  // instructions issued and not yet returned
  logic [7:0] outstanding;
  logic       ready_now;

  // count of failed properties
  int fail_count = 0;

  // both operands known at issue, per the operand rule
  always_comb begin
    case (issue_opcode)
      opc_lui:    ready_now = 1'b1;
      opc_auipc:  ready_now = 1'b1;
      opc_op_imm: ready_now = rs1_ready;
      default:    ready_now = rs1_ready && rs2_ready;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 8'(issue) - 8'(result_valid);
    end
  end

  // result strobe cleared by rst and flush
  assert property (@(posedge clk) (rst || flush) |=> !result_valid)
    else begin
      fail_count++;
      $error("result_valid high after rst or flush");
    end

  // no issue into a full station
  assert property (@(posedge clk) disable iff (rst) issue |-> !full)
    else begin
      fail_count++;
      $error("issue while full");
    end

  // idle station, ready operands
  // result registered two edges after issue, seen at the third sample
  assert property (@(posedge clk) disable iff (rst || flush)
                   (issue && ready_now && outstanding == 0) |-> ##3 result_valid)
    else begin
      fail_count++;
      $error("idle latency is not two edges");
    end

  // every result needs an issue since the last flush
  assert property (@(posedge clk) disable iff (rst) result_valid |-> outstanding != 0)
    else begin
      fail_count++;
      $error("result without an outstanding issue");
    end

endmodule

bind alu_rs_top alu_rs_assertions i_assertions (.*);

// File: rtl/alu_rs_top.sv
`timescale 1ns/10ps

module alu_rs_top
  import alu_rs_pkg::*;
#(
  parameter int NUM_ENTRIES = 8,
  parameter int ROB_TAG_W   = 3,
  parameter int CDB_PORTS   = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  // issue side
  input  logic                 issue,
  input  opcode_t              issue_opcode,
  input  logic [2:0]           issue_funct3,
  input  logic [6:0]           issue_funct7,
  input  word_t                issue_imm,
  input  word_t                issue_pc,
  input  logic [ROB_TAG_W-1:0] issue_rob,
  // register file operands
  input  logic                 rs1_ready,
  input  logic                 rs2_ready,
  input  word_t                rs1_value,
  input  word_t                rs2_value,
  input  logic [ROB_TAG_W-1:0] rs1_rob,
  input  logic [ROB_TAG_W-1:0] rs2_rob,
  // cdb snoop
  input  logic                 cdb_valid [CDB_PORTS],
  input  logic [ROB_TAG_W-1:0] cdb_rob   [CDB_PORTS],
  input  word_t                cdb_value [CDB_PORTS],
  output logic                 full,
  // result toward cdb
  output logic                 result_valid,
  output word_t                result_value,
  output logic [ROB_TAG_W-1:0] result_rob
);

  rs_entry_if #(.ROB_TAG_W(ROB_TAG_W)) entry_bus ();
  exec_req_if #(.ROB_TAG_W(ROB_TAG_W)) req_bus ();

  // stage 1, decode in the issue cycle
  dispatch_decode #(
    .ROB_TAG_W(ROB_TAG_W)
  ) i_decode (
    .issue        (issue),
    .issue_opcode (issue_opcode),
    .issue_funct3 (issue_funct3),
    .issue_funct7 (issue_funct7),
    .issue_imm    (issue_imm),
    .issue_pc     (issue_pc),
    .issue_rob    (issue_rob),
    .rs1_ready    (rs1_ready),
    .rs2_ready    (rs2_ready),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .rs1_rob      (rs1_rob),
    .rs2_rob      (rs2_rob),
    .entry        (entry_bus.source)
  );

  // stage 2, entries, wakeup and select
  rs_station #(
    .NUM_ENTRIES(NUM_ENTRIES),
    .ROB_TAG_W  (ROB_TAG_W),
    .CDB_PORTS  (CDB_PORTS)
  ) i_station (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .entry     (entry_bus.sink),
    .cdb_valid (cdb_valid),
    .cdb_rob   (cdb_rob),
    .cdb_value (cdb_value),
    .full      (full),
    .req       (req_bus.source)
  );

  // stage 3, registered execute
  exec_unit #(
    .ROB_TAG_W(ROB_TAG_W)
  ) i_exec (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .req          (req_bus.sink),
    .result_valid (result_valid),
    .result_value (result_value),
    .result_rob   (result_rob)
  );

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/10ps

module exec_unit
  import alu_rs_pkg::*;
#(
  parameter int ROB_TAG_W = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  exec_req_if.sink             req,
  output logic                 result_valid,
  output word_t                result_value,
  output logic [ROB_TAG_W-1:0] result_rob
);

  // shift amount width, 5 for rv32
  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  word_t              f;

  assign shamt = req.b[SHAMT_W-1:0];

  // adder, shifter and compares folded into one mux
  always_comb begin
    case (req.op)
      alu_add:  f = req.a + req.b;
      alu_sub:  f = req.a - req.b;
      alu_sll:  f = req.a << shamt;
      alu_srl:  f = req.a >> shamt;
      // sign bit fills from the left
      alu_sra:  f = word_t'($signed(req.a) >>> shamt);
      alu_slt:  f = word_t'($signed(req.a) < $signed(req.b));
      alu_sltu: f = word_t'(req.a < req.b);
      alu_xor:  f = req.a ^ req.b;
      alu_or:   f = req.a | req.b;
      alu_and:  f = req.a & req.b;
      default:  f = '0;
    endcase
  end

  // result strobe, dropped on flush
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= req.valid;
    end
  end

  // result payload held until the next request
  always_ff @(posedge clk) begin
    if (req.valid) begin
      result_value <= f;
      result_rob   <= req.rob;
    end
  end

endmodule

// File: rtl/rs_station.sv
`timescale 1ns/10ps

module rs_station
  import alu_rs_pkg::*;
#(
  parameter int NUM_ENTRIES = 8,
  parameter int ROB_TAG_W   = 3,
  parameter int CDB_PORTS   = 3
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  rs_entry_if.sink             entry,
  input  logic                 cdb_valid [CDB_PORTS],
  input  logic [ROB_TAG_W-1:0] cdb_rob   [CDB_PORTS],
  input  word_t                cdb_value [CDB_PORTS],
  output logic                 full,
  exec_req_if.source           req
);

  localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  typedef logic [ROB_TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0]     idx_t;

  // control state per entry
  logic [NUM_ENTRIES-1:0] valid;
  logic [NUM_ENTRIES-1:0] src1_ready;
  logic [NUM_ENTRIES-1:0] src2_ready;

  // payload per entry
  word_t   src1_value [NUM_ENTRIES];
  word_t   src2_value [NUM_ENTRIES];
  tag_t    src1_tag   [NUM_ENTRIES];
  tag_t    src2_tag   [NUM_ENTRIES];
  tag_t    target_rob [NUM_ENTRIES];
  alu_op_t op_arr     [NUM_ENTRIES];

  // rotating select start
  idx_t ptr;

  logic free_found;
  idx_t free_idx;
  logic sel_found;
  idx_t sel_idx;
  logic issue_write;

  // cdb wakeup hits and captured values
  logic [NUM_ENTRIES-1:0] wake1;
  logic [NUM_ENTRIES-1:0] wake2;
  word_t wake1_value [NUM_ENTRIES];
  word_t wake2_value [NUM_ENTRIES];

  assign full        = &valid;
  assign issue_write = entry.valid && free_found;

  // lowest free slot, scanned downward so index 0 wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_found = 1'b1;
        free_idx   = idx_t'(i);
      end
    end
  end

  // first entry with both sources ready, starting at ptr
  always_comb begin : select_search
    idx_t cand;
    sel_found = 1'b0;
    sel_idx   = ptr;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      // wraps by truncation, entry count is a power of two
      cand = ptr + idx_t'(i);
      if (!sel_found && valid[cand] && src1_ready[cand] && src2_ready[cand]) begin
        sel_found = 1'b1;
        sel_idx   = cand;
      end
    end
  end

  // tag match against every cdb port
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      wake1[i]       = 1'b0;
      wake2[i]       = 1'b0;
      wake1_value[i] = '0;
      wake2_value[i] = '0;
      for (int p = 0; p < CDB_PORTS; p++) begin
        // only waiting sources of live entries
        if (cdb_valid[p] && valid[i] && !src1_ready[i] && cdb_rob[p] == src1_tag[i]) begin
          wake1[i]       = 1'b1;
          wake1_value[i] = cdb_value[p];
        end
        if (cdb_valid[p] && valid[i] && !src2_ready[i] && cdb_rob[p] == src2_tag[i]) begin
          wake2[i]       = 1'b1;
          wake2_value[i] = cdb_value[p];
        end
      end
    end
  end

  // valid, ready flags, pointer and request strobe
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      valid      <= '0;
      src1_ready <= '0;
      src2_ready <= '0;
      ptr        <= '0;
      req.valid  <= 1'b0;
    end else begin
      src1_ready <= src1_ready | wake1;
      src2_ready <= src2_ready | wake2;
      // new entry never overlaps a wakeup or the picked slot
      if (issue_write) begin
        valid[free_idx]      <= 1'b1;
        src1_ready[free_idx] <= entry.src1_ready;
        src2_ready[free_idx] <= entry.src2_ready;
      end
      // picked entry is freed as the request loads
      if (sel_found) begin
        valid[sel_idx] <= 1'b0;
        ptr            <= sel_idx + idx_t'(1);
      end
      req.valid <= sel_found;
    end
  end

  // operand values, tags and request payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (wake1[i]) begin
        src1_value[i] <= wake1_value[i];
      end
      if (wake2[i]) begin
        src2_value[i] <= wake2_value[i];
      end
    end
    if (issue_write) begin
      op_arr[free_idx]     <= entry.op;
      src1_value[free_idx] <= entry.src1_value;
      src2_value[free_idx] <= entry.src2_value;
      src1_tag[free_idx]   <= entry.src1_tag;
      src2_tag[free_idx]   <= entry.src2_tag;
      target_rob[free_idx] <= entry.rob;
    end
    if (sel_found) begin
      req.op  <= op_arr[sel_idx];
      req.a   <= src1_value[sel_idx];
      req.b   <= src2_value[sel_idx];
      req.rob <= target_rob[sel_idx];
    end
  end

endmodule

// File: rtl/dispatch_decode.sv
`timescale 1ns/10ps

module dispatch_decode
  import alu_rs_pkg::*;
#(
  parameter int ROB_TAG_W = 3
) (
  input  logic                 issue,
  input  opcode_t              issue_opcode,
  input  logic [2:0]           issue_funct3,
  input  logic [6:0]           issue_funct7,
  input  word_t                issue_imm,
  input  word_t                issue_pc,
  input  logic [ROB_TAG_W-1:0] issue_rob,
  input  logic                 rs1_ready,
  input  logic                 rs2_ready,
  input  word_t                rs1_value,
  input  word_t                rs2_value,
  input  logic [ROB_TAG_W-1:0] rs1_rob,
  input  logic [ROB_TAG_W-1:0] rs2_rob,
  rs_entry_if.source           entry
);

  logic    alt;
  alu_op_t f3_op;

  assign alt = issue_funct7[FUNCT7_ALT_BIT];

  // issue strobe passes straight through, decode is combinational
  assign entry.valid = issue;
  assign entry.rob   = issue_rob;

  // funct3 decode, common to op and op_imm
  always_comb begin
    f3_op = alu_add;
    case (issue_funct3)
      // sub only exists in the register form
      FUNCT3_ADD_SUB: f3_op = (alt && issue_opcode == opc_op) ? alu_sub : alu_add;
      FUNCT3_SLL:     f3_op = alu_sll;
      FUNCT3_SLT:     f3_op = alu_slt;
      FUNCT3_SLTU:    f3_op = alu_sltu;
      FUNCT3_XOR:     f3_op = alu_xor;
      FUNCT3_SR:      f3_op = alt ? alu_sra : alu_srl;
      FUNCT3_OR:      f3_op = alu_or;
      FUNCT3_AND:     f3_op = alu_and;
      default:        f3_op = alu_add;
    endcase
  end

  // lui and auipc are plain adds
  assign entry.op = (issue_opcode == opc_lui || issue_opcode == opc_auipc) ? alu_add : f3_op;

  // operand slots per opcode
  always_comb begin
    // register file by default, tag kept for wakeup
    entry.src1_ready = rs1_ready;
    entry.src1_value = rs1_value;
    entry.src1_tag   = rs1_rob;
    entry.src2_ready = 1'b1;
    entry.src2_value = issue_imm;
    entry.src2_tag   = rs2_rob;
    case (issue_opcode)
      opc_lui: begin
        // 0 + imm
        entry.src1_ready = 1'b1;
        entry.src1_value = '0;
      end
      opc_auipc: begin
        entry.src1_ready = 1'b1;
        entry.src1_value = issue_pc;
      end
      opc_op: begin
        entry.src2_ready = rs2_ready;
        entry.src2_value = rs2_value;
      end
      default: begin
        // op_imm, rs1 plus immediate
        entry.src2_ready = 1'b1;
      end
    endcase
  end

endmodule

// File: rtl/exec_req_if.sv
`timescale 1ns/10ps

interface exec_req_if
  import alu_rs_pkg::*;
#(
  parameter int ROB_TAG_W = 3
) ();

  // one selected instruction, single cycle strobe
  logic                 valid;
  alu_op_t              op;

  // operands already resolved
  word_t                a;
  word_t                b;

  // destination rob slot
  logic [ROB_TAG_W-1:0] rob;

  modport source (output valid, op, a, b, rob);

  modport sink (input valid, op, a, b, rob);

endinterface

// File: rtl/rs_entry_if.sv
`timescale 1ns/10ps

interface rs_entry_if
  import alu_rs_pkg::*;
#(
  parameter int ROB_TAG_W = 3
) ();

  // one decoded instruction, valid for a single cycle
  logic                 valid;
  alu_op_t              op;

  // source 1, value or waiting tag
  logic                 src1_ready;
  word_t                src1_value;
  logic [ROB_TAG_W-1:0] src1_tag;

  // source 2, value or waiting tag
  logic                 src2_ready;
  word_t                src2_value;
  logic [ROB_TAG_W-1:0] src2_tag;

  // rob slot receiving the result
  logic [ROB_TAG_W-1:0] rob;

  modport source (output valid, op, src1_ready, src1_value, src1_tag,
                  output src2_ready, src2_value, src2_tag, rob);

  modport sink (input valid, op, src1_ready, src1_value, src1_tag,
                input src2_ready, src2_value, src2_tag, rob);

endinterface

// File: rtl/alu_rs_pkg.sv
package alu_rs_pkg;

  // data path width, rv32i only
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // major opcodes accepted by the alu station
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  // operation stored per entry after decode
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_t;

  // funct3 field encodings, shared by op and op_imm
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  // srl and sra share this one
  localparam logic [2:0] FUNCT3_SR      = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // funct7 bit picking sub over add, sra over srl
  localparam int FUNCT7_ALT_BIT = 5;

endpackage
